// File: dma_types_pkg.sv
/*
  DMA channel and memory command types
  Widths, channel count and the command payloads sent to the memory engine
*/

package dma_types_pkg;

  // Byte address and word count widths
  localparam int ADDR_W  = 32;
  localparam int COUNT_W = 24;

  // Channels per direction
  localparam int NUM_CH = 2;

  // Selects one of the two channels in a direction
  typedef logic ch_idx_t;

  // Ingress block write, start address plus words in this block
  typedef struct packed {
    logic [ADDR_W-1:0]  addr;
    logic [COUNT_W-1:0] count;
  } wr_cmd_t;

  // Egress block read, size is fixed on the engine side
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } rd_cmd_t;

endpackage

// File: xfer_state_pkg.sv
/*
  Transfer sequencer encodings
  FSM states and the direction code shared by arbiter and sequencer
*/

package xfer_state_pkg;

  // Sequencer FSM states
  typedef enum logic [3:0] {
    IDLE      = 4'h0,
    ING_ISSUE = 4'h1,
    ING_WAIT  = 4'h2,
    EGR_ISSUE = 4'h3,
    EGR_WAIT  = 4'h4
  } xfer_state_t;

  // Direction of a granted transfer
  typedef enum logic {
    DIR_ING = 1'b0,
    DIR_EGR = 1'b1
  } dir_t;

endpackage

// File: path_arbiter.sv
/*
  Path arbiter
  Picks ingress or egress, then a channel within it, alternating on ties.
  Holds off until the sequencer reports the transfer done
*/

module path_arbiter (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_ing_enable [dma_types_pkg::NUM_CH],
  input  logic                   i_egr_enable [dma_types_pkg::NUM_CH],
  input  logic                   i_xfer_done,
  output logic                   o_grant,
  output xfer_state_pkg::dir_t   o_grant_dir,
  output dma_types_pkg::ch_idx_t o_grant_ch
);

  logic                   r_busy;
  xfer_state_pkg::dir_t   r_dir_pri;
  dma_types_pkg::ch_idx_t r_ing_pri;
  dma_types_pkg::ch_idx_t r_egr_pri;

  logic                   w_ing_any;
  logic                   w_egr_any;
  logic                   w_dir_tie;
  xfer_state_pkg::dir_t   w_dir;
  logic                   w_sel_en [dma_types_pkg::NUM_CH];
  logic                   w_ch_tie;
  dma_types_pkg::ch_idx_t w_ch;

  always_comb begin
    w_ing_any = 1'b0;
    w_egr_any = 1'b0;
    for (int c = 0; c < dma_types_pkg::NUM_CH; c++) begin
      w_ing_any = w_ing_any | i_ing_enable[c];
      w_egr_any = w_egr_any | i_egr_enable[c];
    end

    // Direction first with the favored side winning a tie
    w_dir_tie = w_ing_any && w_egr_any;
    if (w_dir_tie) begin
      w_dir = r_dir_pri;
    end else if (w_egr_any) begin
      w_dir = xfer_state_pkg::DIR_EGR;
    end else begin
      w_dir = xfer_state_pkg::DIR_ING;
    end

    for (int c = 0; c < dma_types_pkg::NUM_CH; c++) begin
      w_sel_en[c] = (w_dir == xfer_state_pkg::DIR_EGR) ? i_egr_enable[c] : i_ing_enable[c];
    end

    // Then the channel by that direction's own bit
    w_ch_tie = w_sel_en[0] && w_sel_en[1];
    if (w_ch_tie) begin
      w_ch = (w_dir == xfer_state_pkg::DIR_EGR) ? r_egr_pri : r_ing_pri;
    end else begin
      w_ch = w_sel_en[1];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      r_busy    <= 1'b0;
      o_grant   <= 1'b0;
      r_dir_pri <= xfer_state_pkg::DIR_ING;
      r_ing_pri <= 1'b0;
      r_egr_pri <= 1'b0;
    end else begin
      o_grant <= 1'b0;
      if (!r_busy) begin
        if (w_ing_any || w_egr_any) begin
          o_grant <= 1'b1;
          r_busy  <= 1'b1;
          if (w_dir_tie) begin
            r_dir_pri <= (r_dir_pri == xfer_state_pkg::DIR_ING) ?
                         xfer_state_pkg::DIR_EGR : xfer_state_pkg::DIR_ING;
          end
          if (w_ch_tie) begin
            if (w_dir == xfer_state_pkg::DIR_EGR) begin
              r_egr_pri <= ~r_egr_pri;
            end else begin
              r_ing_pri <= ~r_ing_pri;
            end
          end
        end
      end else if (i_xfer_done) begin
        r_busy <= 1'b0;
      end
    end
  end

  // Direction and channel of the grant being issued
  always_ff @(posedge clk) begin
    if (!r_busy && (w_ing_any || w_egr_any)) begin
      o_grant_dir <= w_dir;
      o_grant_ch  <= w_ch;
    end
  end

endmodule

// File: mem_cmd_port.sv
/*
  Memory engine command port
  Registers a command, pulses go, then follows the engine busy level
  through its rise and fall and pulses done at the end of the block
*/

module mem_cmd_port #(
  parameter type cmd_t = logic
) (
  input  logic clk,
  input  logic rst,
  input  logic i_start,
  input  cmd_t i_cmd,
  input  logic i_bsy,
  output logic o_go,
  output cmd_t o_cmd,
  output logic o_done
);

  typedef enum logic [1:0] {
    PH_IDLE    = 2'd0,
    PH_WAIT_HI = 2'd1,
    PH_WAIT_LO = 2'd2
  } phase_t;

  phase_t r_phase;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_go    <= 1'b0;
      o_done  <= 1'b0;
      r_phase <= PH_IDLE;
    end else begin
      o_go   <= i_start;
      o_done <= 1'b0;
      case (r_phase)
        PH_IDLE: begin
          if (i_start) begin
            r_phase <= PH_WAIT_HI;
          end
        end
        // Engine takes a few cycles to pick up the go
        PH_WAIT_HI: begin
          if (i_bsy) begin
            r_phase <= PH_WAIT_LO;
          end
        end
        PH_WAIT_LO: begin
          if (!i_bsy) begin
            o_done  <= 1'b1;
            r_phase <= PH_IDLE;
          end
        end
        default: begin
          r_phase <= PH_IDLE;
        end
      endcase
    end
  end

  // Command stays put until the next go
  always_ff @(posedge clk) begin
    if (i_start) begin
      o_cmd <= i_cmd;
    end
  end

endmodule

// File: xfer_sequencer.sv
/*
  Transfer sequencer
  Runs one granted transfer block by block against the memory engine.
  Ingress stops on its word count, egress while the channel stays enabled
*/

module xfer_sequencer #(
  parameter int BLOCK_WORDS = 256
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 i_grant,
  input  xfer_state_pkg::dir_t                 i_grant_dir,
  input  dma_types_pkg::ch_idx_t               i_grant_ch,
  input  logic [dma_types_pkg::ADDR_W-1:0]     i_ing_addr   [dma_types_pkg::NUM_CH],
  input  logic [dma_types_pkg::COUNT_W-1:0]    i_ing_count  [dma_types_pkg::NUM_CH],
  input  logic                                 i_egr_enable [dma_types_pkg::NUM_CH],
  input  logic [dma_types_pkg::ADDR_W-1:0]     i_egr_addr   [dma_types_pkg::NUM_CH],
  input  logic                                 i_wr_done,
  input  logic                                 i_rd_done,
  output logic                                 o_wr_start,
  output dma_types_pkg::wr_cmd_t               o_wr_cmd,
  output logic                                 o_rd_start,
  output dma_types_pkg::rd_cmd_t               o_rd_cmd,
  output logic                                 o_ing_finished [dma_types_pkg::NUM_CH],
  output logic                                 o_xfer_done
);

  localparam int AW = dma_types_pkg::ADDR_W;
  localparam int CW = dma_types_pkg::COUNT_W;

  // Block size in words and an egress block in bytes
  localparam logic [CW-1:0] BLK_COUNT = CW'(BLOCK_WORDS);
  localparam logic [AW-1:0] EGR_STEP  = AW'(BLOCK_WORDS * 4);

  xfer_state_pkg::xfer_state_t r_state;
  dma_types_pkg::ch_idx_t      r_ch;
  logic                        r_fin;
  logic [AW-1:0]               r_addr;
  logic [CW-1:0]               r_remain;

  logic [CW-1:0]               w_blk;
  logic [AW-1:0]               w_blk_bytes;

  // Last ingress block may be short
  assign w_blk       = (r_remain < BLK_COUNT) ? r_remain : BLK_COUNT;
  assign w_blk_bytes = AW'(w_blk) << 2;

  assign o_wr_start     = (r_state == xfer_state_pkg::ING_ISSUE);
  assign o_wr_cmd.addr  = r_addr;
  assign o_wr_cmd.count = w_blk;

  assign o_rd_start    = (r_state == xfer_state_pkg::EGR_ISSUE) && i_egr_enable[r_ch];
  assign o_rd_cmd.addr = r_addr;

  always_comb begin
    for (int c = 0; c < dma_types_pkg::NUM_CH; c++) begin
      o_ing_finished[c] = r_fin && (r_ch == dma_types_pkg::ch_idx_t'(c));
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      r_state     <= xfer_state_pkg::IDLE;
      r_ch        <= 1'b0;
      r_fin       <= 1'b0;
      o_xfer_done <= 1'b0;
    end else begin
      r_fin       <= 1'b0;
      o_xfer_done <= 1'b0;
      case (r_state)
        xfer_state_pkg::IDLE: begin
          if (i_grant) begin
            r_ch <= i_grant_ch;
            if (i_grant_dir == xfer_state_pkg::DIR_EGR) begin
              r_state <= xfer_state_pkg::EGR_ISSUE;
            end else if (i_ing_count[i_grant_ch] == '0) begin
              // Nothing to move, just report finished
              r_fin       <= 1'b1;
              o_xfer_done <= 1'b1;
            end else begin
              r_state <= xfer_state_pkg::ING_ISSUE;
            end
          end
        end
        xfer_state_pkg::ING_ISSUE: begin
          r_state <= xfer_state_pkg::ING_WAIT;
        end
        xfer_state_pkg::ING_WAIT: begin
          if (i_wr_done) begin
            if (r_remain == '0) begin
              r_fin       <= 1'b1;
              o_xfer_done <= 1'b1;
              r_state     <= xfer_state_pkg::IDLE;
            end else begin
              r_state <= xfer_state_pkg::ING_ISSUE;
            end
          end
        end
        xfer_state_pkg::EGR_ISSUE: begin
          if (i_egr_enable[r_ch]) begin
            r_state <= xfer_state_pkg::EGR_WAIT;
          end else begin
            o_xfer_done <= 1'b1;
            r_state     <= xfer_state_pkg::IDLE;
          end
        end
        xfer_state_pkg::EGR_WAIT: begin
          if (i_rd_done) begin
            r_state <= xfer_state_pkg::EGR_ISSUE;
          end
        end
        default: begin
          r_state <= xfer_state_pkg::IDLE;
        end
      endcase
    end
  end

  // Address and remaining words, advanced as each block is issued
  always_ff @(posedge clk) begin
    if ((r_state == xfer_state_pkg::IDLE) && i_grant) begin
      if (i_grant_dir == xfer_state_pkg::DIR_EGR) begin
        r_addr <= i_egr_addr[i_grant_ch];
      end else begin
        r_addr <= i_ing_addr[i_grant_ch];
      end
      r_remain <= i_ing_count[i_grant_ch];
    end else if (o_wr_start) begin
      r_addr   <= r_addr + w_blk_bytes;
      r_remain <= r_remain - w_blk;
    end else if (o_rd_start) begin
      r_addr <= r_addr + EGR_STEP;
    end
  end

endmodule

// File: ddr3_arbiter_controller.sv
/*
  Memory access arbiter top level
  Two ingress and two egress DMA channels sharing one block memory engine
*/

module ddr3_arbiter_controller #(
  parameter int BLOCK_WORDS = 256
) (
  input  logic                              clk,
  input  logic                              rst,

  // Ingress DMA channels
  input  logic                              i_ing_enable   [dma_types_pkg::NUM_CH],
  input  logic [dma_types_pkg::ADDR_W-1:0]  i_ing_addr     [dma_types_pkg::NUM_CH],
  input  logic [dma_types_pkg::COUNT_W-1:0] i_ing_count    [dma_types_pkg::NUM_CH],
  output logic                              o_ing_finished [dma_types_pkg::NUM_CH],

  // Egress DMA channels
  input  logic                              i_egr_enable   [dma_types_pkg::NUM_CH],
  input  logic [dma_types_pkg::ADDR_W-1:0]  i_egr_addr     [dma_types_pkg::NUM_CH],

  // Memory engine, write side
  output logic                              o_ibuf_go,
  output dma_types_pkg::wr_cmd_t            o_ibuf_cmd,
  input  logic                              i_ibuf_bsy,

  // Memory engine, read side
  output logic                              o_obuf_go,
  output dma_types_pkg::rd_cmd_t            o_obuf_cmd,
  input  logic                              i_obuf_bsy
);

  logic                   w_grant;
  xfer_state_pkg::dir_t   w_grant_dir;
  dma_types_pkg::ch_idx_t w_grant_ch;
  logic                   w_xfer_done;

  logic                   w_wr_start;
  dma_types_pkg::wr_cmd_t w_wr_cmd;
  logic                   w_wr_done;
  logic                   w_rd_start;
  dma_types_pkg::rd_cmd_t w_rd_cmd;
  logic                   w_rd_done;

  path_arbiter arbiter (
    .clk          (clk),
    .rst          (rst),
    .i_ing_enable (i_ing_enable),
    .i_egr_enable (i_egr_enable),
    .i_xfer_done  (w_xfer_done),
    .o_grant      (w_grant),
    .o_grant_dir  (w_grant_dir),
    .o_grant_ch   (w_grant_ch)
  );

  xfer_sequencer #(
    .BLOCK_WORDS (BLOCK_WORDS)
  ) sequencer (
    .clk            (clk),
    .rst            (rst),
    .i_grant        (w_grant),
    .i_grant_dir    (w_grant_dir),
    .i_grant_ch     (w_grant_ch),
    .i_ing_addr     (i_ing_addr),
    .i_ing_count    (i_ing_count),
    .i_egr_enable   (i_egr_enable),
    .i_egr_addr     (i_egr_addr),
    .i_wr_done      (w_wr_done),
    .i_rd_done      (w_rd_done),
    .o_wr_start     (w_wr_start),
    .o_wr_cmd       (w_wr_cmd),
    .o_rd_start     (w_rd_start),
    .o_rd_cmd       (w_rd_cmd),
    .o_ing_finished (o_ing_finished),
    .o_xfer_done    (w_xfer_done)
  );

  // Ingress blocks go out as writes
  mem_cmd_port #(
    .cmd_t (dma_types_pkg::wr_cmd_t)
  ) wr_port (
    .clk     (clk),
    .rst     (rst),
    .i_start (w_wr_start),
    .i_cmd   (w_wr_cmd),
    .i_bsy   (i_ibuf_bsy),
    .o_go    (o_ibuf_go),
    .o_cmd   (o_ibuf_cmd),
    .o_done  (w_wr_done)
  );

  // Egress blocks go out as reads
  mem_cmd_port #(
    .cmd_t (dma_types_pkg::rd_cmd_t)
  ) rd_port (
    .clk     (clk),
    .rst     (rst),
    .i_start (w_rd_start),
    .i_cmd   (w_rd_cmd),
    .i_bsy   (i_obuf_bsy),
    .o_go    (o_obuf_go),
    .o_cmd   (o_obuf_cmd),
    .o_done  (w_rd_done)
  );

endmodule

// File: ddr3_arbiter_checker.sv
/*
  Protocol assertions on the memory engine commands and finished lines
*/

module ddr3_arbiter_checker (
  input logic clk,
  input logic rst,
  input logic i_ibuf_go,
  input logic i_obuf_go,
  input logic i_ibuf_bsy,
  input logic i_obuf_bsy,
  input logic i_ing_finished [dma_types_pkg::NUM_CH]
);

  // Number of failed assertions
  int fail_count = 0;

  // One block in flight, so never both directions at once
  assert property (@(posedge clk) disable iff (rst) !(i_ibuf_go && i_obuf_go))
    else begin
      fail_count++;
      $error("write go and read go high in the same cycle");
    end

  assert property (@(posedge clk) disable iff (rst) i_ibuf_go |=> !i_ibuf_go)
    else begin
      fail_count++;
      $error("write go held longer than one cycle");
    end

  assert property (@(posedge clk) disable iff (rst) i_obuf_go |=> !i_obuf_go)
    else begin
      fail_count++;
      $error("read go held longer than one cycle");
    end

  assert property (@(posedge clk) disable iff (rst)
                   !(i_ing_finished[0] && i_ing_finished[1]))
    else begin
      fail_count++;
      $error("finished pulse on both ingress channels together");
    end

  // Engine must be idle when a new block is handed over
  assert property (@(posedge clk) disable iff (rst) !(i_ibuf_go && i_ibuf_bsy))
    else begin
      fail_count++;
      $error("write go while the write side is busy");
    end

  assert property (@(posedge clk) disable iff (rst) !(i_obuf_go && i_obuf_bsy))
    else begin
      fail_count++;
      $error("read go while the read side is busy");
    end

endmodule

bind ddr3_arbiter_controller ddr3_arbiter_checker arb_chk (
  .clk            (clk),
  .rst            (rst),
  .i_ibuf_go      (o_ibuf_go),
  .i_obuf_go      (o_obuf_go),
  .i_ibuf_bsy     (i_ibuf_bsy),
  .i_obuf_bsy     (i_obuf_bsy),
  .i_ing_finished (o_ing_finished)
);

// File: ddr3_arbiter_controller_tb.sv
/*
  Testbench for the memory access arbiter
  Table of DMA requests, a memory engine model and in-order command checks
*/

module ddr3_arbiter_controller_tb;

  localparam int BLOCK_WORDS = 256;
  localparam int AW = dma_types_pkg::ADDR_W;
  localparam int CW = dma_types_pkg::COUNT_W;
  localparam int NUM_ROWS = 9;
  localparam int SETTLE = 20;
  localparam int EV_WR = 0;
  localparam int EV_RD = 1;
  localparam int EV_FIN = 2;

  logic                   clk;
  logic                   rst;
  logic                   ing_enable [2];
  logic [AW-1:0]          ing_addr [2];
  logic [CW-1:0]          ing_count [2];
  logic                   ing_finished [2];
  logic                   egr_enable [2];
  logic [AW-1:0]          egr_addr [2];
  logic                   ibuf_go;
  dma_types_pkg::wr_cmd_t ibuf_cmd;
  logic                   ibuf_bsy;
  logic                   obuf_go;
  dma_types_pkg::rd_cmd_t obuf_cmd;
  logic                   obuf_bsy;

  // Request table where ingress count -1 or egress 0 blocks leaves a channel off
  int            tbl_ing_cnt [NUM_ROWS][2];
  logic [AW-1:0] tbl_ing_addr [NUM_ROWS][2];
  int            tbl_egr_blk [NUM_ROWS][2];
  logic [AW-1:0] tbl_egr_addr [NUM_ROWS][2];

  // Expected events in the order they must appear
  int            exp_kind [$];
  int            exp_ch [$];
  logic [AW-1:0] exp_addr [$];
  logic [CW-1:0] exp_cnt [$];

  // Reference copy of the tie-break bits
  logic pri_dir;
  logic pri_ing;
  logic pri_egr;

  int   cur_row;
  int   row_err;
  int   err_total;
  int   events;
  int   timeout_limit;
  int   cycle_count = 0;
  int   egr_gos [2];
  logic drop_ing [2];
  logic drop_egr [2];

  ddr3_arbiter_controller #(
    .BLOCK_WORDS (BLOCK_WORDS)
  ) uut (
    .clk            (clk),
    .rst            (rst),
    .i_ing_enable   (ing_enable),
    .i_ing_addr     (ing_addr),
    .i_ing_count    (ing_count),
    .o_ing_finished (ing_finished),
    .i_egr_enable   (egr_enable),
    .i_egr_addr     (egr_addr),
    .o_ibuf_go      (ibuf_go),
    .o_ibuf_cmd     (ibuf_cmd),
    .i_ibuf_bsy     (ibuf_bsy),
    .o_obuf_go      (obuf_go),
    .o_obuf_cmd     (obuf_cmd),
    .i_obuf_bsy     (obuf_bsy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Memory engine model raising busy 1 to 4 cycles after go for 2 to 6 cycles
  initial begin
    int unsigned lat;
    int unsigned hold;
    logic        is_rd;
    ibuf_bsy = 1'b0;
    obuf_bsy = 1'b0;
    void'($urandom(32'hfc315d89));
    forever begin
      @(negedge clk);
      if (ibuf_go || obuf_go) begin
        is_rd = obuf_go;
        lat = 1 + ($urandom % 4);
        hold = 2 + ($urandom % 5);
        repeat (lat) @(posedge clk);
        #1;
        if (is_rd) begin
          obuf_bsy = 1'b1;
        end else begin
          ibuf_bsy = 1'b1;
        end
        repeat (hold) @(posedge clk);
        #1;
        obuf_bsy = 1'b0;
        ibuf_bsy = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("ERROR: timeout after %0d cycles before the table was done", cycle_count);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task set_row(input int r, input int ic0, input logic [AW-1:0] ia0, input int ic1,
               input logic [AW-1:0] ia1, input int eb0, input logic [AW-1:0] ea0,
               input int eb1, input logic [AW-1:0] ea1);
    tbl_ing_cnt[r][0] = ic0;
    tbl_ing_addr[r][0] = ia0;
    tbl_ing_cnt[r][1] = ic1;
    tbl_ing_addr[r][1] = ia1;
    tbl_egr_blk[r][0] = eb0;
    tbl_egr_addr[r][0] = ea0;
    tbl_egr_blk[r][1] = eb1;
    tbl_egr_addr[r][1] = ea1;
  endtask

  function int count_blocks();
    int total;
    total = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int c = 0; c < 2; c++) begin
        // A zero-count request still costs a grant
        if (tbl_ing_cnt[r][c] == 0) begin
          total = total + 1;
        end else if (tbl_ing_cnt[r][c] > 0) begin
          total = total + (tbl_ing_cnt[r][c] + BLOCK_WORDS - 1) / BLOCK_WORDS;
        end
        total = total + tbl_egr_blk[r][c];
      end
    end
    return total;
  endfunction

  function string ev_name(input int kind);
    case (kind)
      EV_WR:   return "write go";
      EV_RD:   return "read go";
      default: return "finished pulse";
    endcase
  endfunction

  task push_event(input int kind, input int ch, input logic [AW-1:0] addr,
                  input logic [CW-1:0] cnt);
    exp_kind.push_back(kind);
    exp_ch.push_back(ch);
    exp_addr.push_back(addr);
    exp_cnt.push_back(cnt);
  endtask

  task queue_ingress(input int r, input int ch);
    int            left;
    int            blk;
    logic [AW-1:0] a;
    left = tbl_ing_cnt[r][ch];
    a = tbl_ing_addr[r][ch];
    while (left > 0) begin
      blk = (left < BLOCK_WORDS) ? left : BLOCK_WORDS;
      push_event(EV_WR, ch, a, CW'(blk));
      a = a + AW'(4 * blk);
      left = left - blk;
    end
    push_event(EV_FIN, ch, '0, '0);
  endtask

  task queue_egress(input int r, input int ch);
    for (int k = 0; k < tbl_egr_blk[r][ch]; k++) begin
      push_event(EV_RD, ch, tbl_egr_addr[r][ch] + AW'(k * BLOCK_WORDS * 4), '0);
    end
  endtask

  // Replays the arbitration rules over the channels enabled in row r
  task build_expected(input int r);
    logic ing_pend [2];
    logic egr_pend [2];
    logic take_egr;
    int   ch;
    for (int c = 0; c < 2; c++) begin
      ing_pend[c] = (tbl_ing_cnt[r][c] >= 0);
      egr_pend[c] = (tbl_egr_blk[r][c] > 0);
    end
    while (ing_pend[0] || ing_pend[1] || egr_pend[0] || egr_pend[1]) begin
      if ((ing_pend[0] || ing_pend[1]) && (egr_pend[0] || egr_pend[1])) begin
        take_egr = pri_dir;
        pri_dir = !pri_dir;
      end else begin
        take_egr = egr_pend[0] || egr_pend[1];
      end
      if (take_egr) begin
        if (egr_pend[0] && egr_pend[1]) begin
          ch = pri_egr ? 1 : 0;
          pri_egr = !pri_egr;
        end else begin
          ch = egr_pend[1] ? 1 : 0;
        end
        queue_egress(r, ch);
        egr_pend[ch] = 1'b0;
      end else begin
        if (ing_pend[0] && ing_pend[1]) begin
          ch = pri_ing ? 1 : 0;
          pri_ing = !pri_ing;
        end else begin
          ch = ing_pend[1] ? 1 : 0;
        end
        queue_ingress(r, ch);
        ing_pend[ch] = 1'b0;
      end
    end
  endtask

  task check_event(input int kind, input int ch, input logic [AW-1:0] addr,
                   input logic [CW-1:0] cnt);
    int            e_kind;
    int            e_ch;
    logic [AW-1:0] e_addr;
    logic [CW-1:0] e_cnt;
    events++;
    if (exp_kind.size() == 0) begin
      $display("ERROR: unexpected %s with nothing left to expect", ev_name(kind));
      row_err++;
    end else begin
      e_kind = exp_kind.pop_front();
      e_ch = exp_ch.pop_front();
      e_addr = exp_addr.pop_front();
      e_cnt = exp_cnt.pop_front();
      if (e_kind != kind) begin
        $display("ERROR: %s seen where a %s was expected", ev_name(kind), ev_name(e_kind));
        row_err++;
      end else if (kind == EV_FIN) begin
        if (e_ch != ch) begin
          $display("MISMATCH o_ing_finished channel expected 0x%0h got 0x%0h", e_ch, ch);
          row_err++;
        end
      end else begin
        if (e_addr !== addr) begin
          $display("MISMATCH %s expected 0x%h got 0x%h",
                   (kind == EV_WR) ? "o_ibuf_cmd.addr" : "o_obuf_cmd.addr", e_addr, addr);
          row_err++;
        end
        if (kind == EV_WR && e_cnt !== cnt) begin
          $display("MISMATCH o_ibuf_cmd.count expected 0x%h got 0x%h", e_cnt, cnt);
          row_err++;
        end
        // Egress channel lets go after its allowed number of blocks
        if (kind == EV_RD) begin
          egr_gos[e_ch]++;
          if (egr_gos[e_ch] == tbl_egr_blk[cur_row][e_ch]) begin
            drop_egr[e_ch] = 1'b1;
          end
        end
      end
    end
  endtask

  // Sample at the falling edge and drive just after the rising edge
  task step_cycle();
    @(negedge clk);
    if (ibuf_go) begin
      check_event(EV_WR, 0, ibuf_cmd.addr, ibuf_cmd.count);
    end
    if (obuf_go) begin
      check_event(EV_RD, 0, obuf_cmd.addr, '0);
    end
    for (int c = 0; c < 2; c++) begin
      if (ing_finished[c]) begin
        check_event(EV_FIN, c, '0, '0);
        drop_ing[c] = 1'b1;
      end
    end
    @(posedge clk);
    #1;
    for (int c = 0; c < 2; c++) begin
      if (drop_ing[c]) begin
        ing_enable[c] = 1'b0;
      end
      if (drop_egr[c]) begin
        egr_enable[c] = 1'b0;
      end
      drop_ing[c] = 1'b0;
      drop_egr[c] = 1'b0;
    end
  endtask

  task run_row(input int r);
    int n_exp;
    cur_row = r;
    row_err = 0;
    build_expected(r);
    n_exp = exp_kind.size();
    for (int c = 0; c < 2; c++) begin
      egr_gos[c] = 0;
      ing_enable[c] = (tbl_ing_cnt[r][c] >= 0);
      ing_addr[c] = tbl_ing_addr[r][c];
      ing_count[c] = (tbl_ing_cnt[r][c] > 0) ? CW'(tbl_ing_cnt[r][c]) : '0;
      egr_enable[c] = (tbl_egr_blk[r][c] > 0);
      egr_addr[c] = tbl_egr_addr[r][c];
    end
    while (exp_kind.size() > 0) begin
      step_cycle();
    end
    // Quiet period catches extra commands and stray finished pulses
    repeat (SETTLE) begin
      step_cycle();
    end
    $display("row %0d done: %0d expected events, %0d errors", r, n_exp, row_err);
    err_total = err_total + row_err;
  endtask

  initial begin
    rst = 1'b1;
    for (int c = 0; c < 2; c++) begin
      ing_enable[c] = 1'b0;
      ing_addr[c] = '0;
      ing_count[c] = '0;
      egr_enable[c] = 1'b0;
      egr_addr[c] = '0;
      drop_ing[c] = 1'b0;
      drop_egr[c] = 1'b0;
    end
    pri_dir = 1'b0;
    pri_ing = 1'b0;
    pri_egr = 1'b0;
    err_total = 0;
    events = 0;
    //        ing0 count/addr     ing1 count/addr     egr0 blocks/addr  egr1 blocks/addr
    set_row(0, -1,  32'h0,    -1,  32'h0,    0, 32'h0,    0, 32'h0);
    set_row(1, 600, 32'h1000, -1,  32'h0,    0, 32'h0,    0, 32'h0);
    set_row(2, -1,  32'h0,    0,   32'h2000, 0, 32'h0,    0, 32'h0);
    set_row(3, -1,  32'h0,    -1,  32'h0,    3, 32'h8000, 0, 32'h0);
    set_row(4, 300, 32'h3000, 100, 32'h4000, 0, 32'h0,    0, 32'h0);
    set_row(5, 40,  32'h5000, 512, 32'h6000, 0, 32'h0,    0, 32'h0);
    set_row(6, 256, 32'h7000, -1,  32'h0,    0, 32'h0,    2, 32'ha000);
    set_row(7, -1,  32'h0,    20,  32'h9000, 1, 32'hc000, 0, 32'h0);
    set_row(8, -1,  32'h0,    -1,  32'h0,    1, 32'hd000, 1, 32'he000);
    timeout_limit = count_blocks() * 20 + 200;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    err_total = err_total + uut.arb_chk.fail_count;
    $display("summary: %0d rows, %0d events checked, %0d errors", NUM_ROWS, events, err_total);
    if (err_total == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: ddr3_arbiter_controller.f
dma_types_pkg.sv
xfer_state_pkg.sv
path_arbiter.sv
mem_cmd_port.sv
xfer_sequencer.sv
ddr3_arbiter_controller.sv
ddr3_arbiter_checker.sv
ddr3_arbiter_controller_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the arbiter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module ddr3_arbiter_controller_tb \
  -f ddr3_arbiter_controller.f

# Run past assertion errors so the testbench can count them
output=$(./obj_dir/Vddr3_arbiter_controller_tb +verilator+error+limit+1000) || true
echo "$output"

if grep -qx "TESTBENCH PASSED" <<< "$output"; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
